// ==== project.f ====
source/tpu_pkg.sv
source/global_buffer.sv
source/pe_row.sv
source/operand_loader.sv
source/result_store.sv
source/tpu_cmd_ctrl.sv
source/tpu_top.sv
tests/tpu_checker.sv
tests/tpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the TPU testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
        --top-module tpu_tb -f project.f -o Vtpu_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtpu_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1

// ==== tests/tpu_tb.sv ====
`timescale 1ns/100ps

module tpu_tb;

    localparam int ROWS  = 4;
    localparam int DEPTH = 2 ** tpu_pkg::ADDR_BITS;
    // fill of 512 writes, six runs near 120 cycles each, reads, then margin
    localparam int MAX_CYCLES = 4000;

    logic               clk_i;
    logic               rst_i;
    logic               cmd_valid_i;
    tpu_pkg::tpu_cmd_t  cmd_i;
    logic               busy_o;
    logic               rdata_valid_o;
    tpu_pkg::acc_row_t  rdata_o;

    // reference copies of buffers and registers
    logic [31:0]        a_mem [DEPTH];
    logic [31:0]        w_mem [DEPTH];
    tpu_pkg::acc_row_t  c_mem [DEPTH];
    logic [7:0]         row_idx [ROWS];
    logic [7:0]         st_idx [ROWS];
    logic [7:0]         k_reg = '0;

    logic [31:0]        rng_state = 32'h56ea;
    int                 cycles = 0;
    int                 rvalid_count = 0;
    int                 test_errors = 0;
    int                 tests_passed = 0;
    int                 tests_failed = 0;

    tpu_top #(.ROWS(ROWS)) tpu_top_i (
        .clk_i(clk_i), .rst_i(rst_i), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
        .busy_o(busy_o), .rdata_valid_o(rdata_valid_o), .rdata_o(rdata_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // cycle limit and read pulse count
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (rdata_valid_o) begin
            rvalid_count <= rvalid_count + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // xorshift32
    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic expect_eq(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // *********************************************************************
    // command port, called on a falling edge, returns one cycle later
    // *********************************************************************
    task automatic send_cmd(input tpu_pkg::tpu_op_e op, input logic [31:0] p1,
                            input logic [31:0] p2);
        cmd_valid_i   = 1'b1;
        cmd_i.op      = op;
        cmd_i.param_1 = p1;
        cmd_i.param_2 = p2;
        @(negedge clk_i);
        cmd_valid_i = 1'b0;
    endtask

    task automatic read_ram(input logic [1:0] sel, input logic [7:0] idx,
                            output tpu_pkg::acc_row_t data);
        int waited;
        waited = 0;
        send_cmd(tpu_pkg::OP_READ_RAM, 32'(sel), 32'(idx));
        while (!rdata_valid_o && waited < 10) begin
            @(negedge clk_i);
            waited++;
        end
        assert (rdata_valid_o) else begin
            $display("read of buffer %0d at index %0d returned no data", sel, idx);
            test_errors++;
        end
        // second falling edge after the command was driven
        expect_eq(128'(waited), 128'd1, "read latency");
        data = rdata_o;
        @(negedge clk_i);
        // a single pulse per read
        assert (!rdata_valid_o) else begin
            $display("rdata_valid_o stayed high longer than one cycle after a read");
            test_errors++;
        end
    endtask

    // K, random row starts, store indices spaced by a gap from a base
    task automatic configure(input int k, input logic [7:0] st_base, input int st_gap);
        k_reg = 8'(k);
        send_cmd(tpu_pkg::OP_SET_K, 32'd0, 32'(k));
        for (int i = 0; i < ROWS; i++) begin
            row_idx[i] = 8'(rand32());
            st_idx[i]  = st_base + 8'(st_gap * i);
            send_cmd(tpu_pkg::OP_SET_ROW_IDX, 32'(i), 32'(row_idx[i]));
            send_cmd(tpu_pkg::OP_SET_ST_IDX, 32'(i), 32'(st_idx[i]));
        end
    endtask

    // step rule: signed A low byte times each signed W lane, wrapped sums
    task automatic model_run();
        int                 kk;
        logic signed [31:0] acc_sum;
        logic [7:0]         a_addr;
        kk = (k_reg == 0) ? 1 : int'(k_reg);
        for (int i = 0; i < ROWS; i++) begin
            for (int j = 0; j < tpu_pkg::LANES; j++) begin
                acc_sum = 0;
                for (int s = 0; s < kk; s++) begin
                    a_addr  = row_idx[i] + 8'(s);
                    acc_sum = acc_sum + $signed(a_mem[a_addr][7:0]) * $signed(w_mem[s][8*j +: 8]);
                end
                c_mem[st_idx[i]][j] = acc_sum;
            end
        end
        for (int i = 0; i < ROWS; i++) begin
            st_idx[i] = st_idx[i] + 8'd1;
        end
    endtask

    task automatic start_run();
        send_cmd(tpu_pkg::OP_TRIGGER, 32'd0, 32'd0);
        assert (busy_o) else begin
            $display("busy_o did not rise after a trigger");
            test_errors++;
        end
    endtask

    task automatic wait_run_end();
        int waited;
        waited = 0;
        while (busy_o && waited < 200) begin
            @(negedge clk_i);
            waited++;
        end
        assert (!busy_o) else begin
            $display("busy_o stayed high for 200 cycles after a trigger");
            test_errors++;
        end
        model_run();
    endtask

    // rows of a run, back counts runs since then
    task automatic check_rows(input int back, input string what);
        tpu_pkg::acc_row_t  data;
        logic [7:0]         idx;
        for (int i = 0; i < ROWS; i++) begin
            idx = st_idx[i] - 8'(back);
            read_ram(tpu_pkg::RAM_C, idx, data);
            expect_eq(data, c_mem[idx], $sformatf("%s row %0d at C[%0d]", what, i, idx));
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // *********************************************************************
    // test sequence
    // *********************************************************************
    initial begin
        tpu_pkg::acc_row_t  data;
        logic [7:0]         idx;
        int                 base_count;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        rst_i       = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            row_idx[i] = '0;
            st_idx[i]  = '0;
        end
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        // read-back, after filling every A and W word
        for (int i = 0; i < DEPTH; i++) begin
            a_mem[i] = rand32();
            w_mem[i] = rand32();
            send_cmd(tpu_pkg::OP_WRITE_A, 32'(i), a_mem[i]);
            send_cmd(tpu_pkg::OP_WRITE_W, 32'(i), w_mem[i]);
        end
        for (int n = 0; n < 8; n++) begin
            idx = 8'(rand32());
            read_ram(tpu_pkg::RAM_A, idx, data);
            expect_eq(data, {96'd0, a_mem[idx]}, $sformatf("A[%0d]", idx));
            idx = 8'(rand32());
            read_ram(tpu_pkg::RAM_W, idx, data);
            expect_eq(data, {96'd0, w_mem[idx]}, $sformatf("W[%0d]", idx));
        end
        finish_test("read_back");

        // K of one, store indices 0 to 3
        configure(1, 8'd0, 1);
        start_run();
        wait_run_end();
        check_rows(1, "single step");
        finish_test("single_step");

        // random K from 2 to 16
        for (int r = 0; r < 3; r++) begin
            configure(2 + int'(rand32() % 15), 8'(rand32()), 2);
            start_run();
            wait_run_end();
            check_rows(1, $sformatf("run %0d K %0d", r, k_reg));
        end
        finish_test("multi_step");

        // new row starts only, store indices carry on from the last run
        for (int i = 0; i < ROWS; i++) begin
            row_idx[i] = 8'(rand32());
            send_cmd(tpu_pkg::OP_SET_ROW_IDX, 32'(i), 32'(row_idx[i]));
        end
        start_run();
        wait_run_end();
        check_rows(1, "advanced");
        check_rows(2, "earlier");
        finish_test("store_advance");

        // write and read sent during a run must be dropped
        configure(16, 8'(rand32()), 2);
        idx        = 8'(rand32());
        base_count = rvalid_count;
        start_run();
        send_cmd(tpu_pkg::OP_WRITE_A, 32'(idx), ~a_mem[idx]);
        send_cmd(tpu_pkg::OP_READ_RAM, 32'(tpu_pkg::RAM_A), 32'(idx));
        wait_run_end();
        repeat (3) @(negedge clk_i);
        expect_eq(128'(rvalid_count), 128'(base_count), "read pulses while busy");
        read_ram(tpu_pkg::RAM_A, idx, data);
        expect_eq(data, {96'd0, a_mem[idx]}, $sformatf("A[%0d] after busy write", idx));
        check_rows(1, "busy run");
        finish_test("ignore_busy");

        $display("tests ok: %0d, with errors: %0d, checker assertion failures: %0d",
                 tests_passed, tests_failed, tpu_top_i.tpu_checker_i.fail_count);
        if (tests_failed == 0 && tpu_top_i.tpu_checker_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/tpu_checker.sv ====
`timescale 1ns/100ps

module tpu_checker (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t   cmd_i,
    input  logic                busy_i,
    input  logic                rdata_valid_i
);

    // failures seen so far, read by the testbench at the end
    int unsigned    fail_count = 0;
    logic           rst_q;
    logic           read_accept;
    logic           read_q1;
    logic           read_q2;

    // a read lands only while idle
    assign read_accept = cmd_valid_i && !busy_i && (cmd_i.op == tpu_pkg::OP_READ_RAM);

    // *********************************************************************
    // accepted read pipeline, two stages
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        rst_q <= rst_i;
        if (rst_i) begin
            read_q1 <= 1'b0;
            read_q2 <= 1'b0;
        end else begin
            read_q1 <= read_accept;
            read_q2 <= read_q1;
        end
    end

    // outputs quiet right after a reset edge
    reset_quiet: assert property (@(posedge clk_i) rst_q |-> (!busy_i && !rdata_valid_i))
        else begin
            fail_count++;
            $error("busy_o or rdata_valid_o high after reset");
        end

    // no read data may start while a run holds the buffers
    no_read_while_busy: assert property (
        @(posedge clk_i) disable iff (rst_i) busy_i |-> !$rose(rdata_valid_i))
        else begin
            fail_count++;
            $error("rdata_valid_o rose while busy_o was high");
        end

    // read data two cycles after the accepting edge
    read_latency: assert property (@(posedge clk_i) disable iff (rst_i) read_q2 |-> rdata_valid_i)
        else begin
            fail_count++;
            $error("rdata_valid_o missing two cycles after an accepted read");
        end

endmodule

bind tpu_top tpu_checker tpu_checker_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_i(cmd_i),
    .busy_i(busy_o),
    .rdata_valid_i(rdata_valid_o)
);

// ==== source/tpu_top.sv ====
`timescale 1ns/100ps

module tpu_top #(
    parameter int ROWS = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t   cmd_i,
    output logic                busy_o,
    output logic                rdata_valid_o,
    output tpu_pkg::acc_row_t   rdata_o
);

    // engine requests and muxed buffer ports
    tpu_pkg::ram_req_t                          ld_a_req;
    tpu_pkg::ram_req_t                          ld_w_req;
    tpu_pkg::ram_req_t                          st_c_req;
    tpu_pkg::ram_req_t                          a_req;
    tpu_pkg::ram_req_t                          w_req;
    tpu_pkg::ram_req_t                          c_req;
    // buffer data
    logic [tpu_pkg::DATA_BITS-1:0]              a_rdata;
    logic [tpu_pkg::DATA_BITS-1:0]              w_rdata;
    tpu_pkg::acc_row_t                          c_rdata;
    tpu_pkg::acc_row_t                          c_wdata;
    // configuration and sequencing
    logic                                       start;
    logic [tpu_pkg::ADDR_BITS-1:0]              k;
    logic [ROWS-1:0][tpu_pkg::ADDR_BITS-1:0]    row_idx;
    logic                                       st_idx_wr;
    logic [tpu_pkg::DATA_BITS-1:0]              st_idx_sel;
    logic [tpu_pkg::ADDR_BITS-1:0]              st_idx_val;
    logic                                       load_done;
    logic                                       store_done;
    // MAC datapath
    tpu_pkg::mac_step_t                         step;
    tpu_pkg::sbyte_t [ROWS-1:0]                 row_ops;
    tpu_pkg::acc_row_t [ROWS-1:0]               acc_rows;

    tpu_cmd_ctrl #(.ROWS(ROWS)) tpu_cmd_ctrl_i (
        .clk_i(clk_i), .rst_i(rst_i), .cmd_valid_i(cmd_valid_i), .cmd_i(cmd_i),
        .ld_a_req_i(ld_a_req), .ld_w_req_i(ld_w_req), .st_c_req_i(st_c_req),
        .a_rdata_i(a_rdata), .w_rdata_i(w_rdata), .c_rdata_i(c_rdata),
        .store_done_i(store_done), .start_o(start), .k_o(k), .row_idx_o(row_idx),
        .st_idx_wr_o(st_idx_wr), .st_idx_sel_o(st_idx_sel), .st_idx_val_o(st_idx_val),
        .a_req_o(a_req), .w_req_o(w_req), .c_req_o(c_req),
        .busy_o(busy_o), .rdata_valid_o(rdata_valid_o), .rdata_o(rdata_o)
    );

    operand_loader #(.ROWS(ROWS)) operand_loader_i (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(start), .k_i(k), .row_idx_i(row_idx),
        .a_rdata_i(a_rdata), .w_rdata_i(w_rdata), .a_req_o(ld_a_req), .w_req_o(ld_w_req),
        .step_o(step), .row_ops_o(row_ops), .load_done_o(load_done)
    );

    // *********************************************************************
    // buffers
    // *********************************************************************
    global_buffer #(.ADDR_BITS(tpu_pkg::ADDR_BITS), .WIDTH(tpu_pkg::DATA_BITS)) a_buf (
        .clk_i(clk_i), .req_i(a_req), .wdata_i(a_req.wdata), .rdata_o(a_rdata)
    );

    global_buffer #(.ADDR_BITS(tpu_pkg::ADDR_BITS), .WIDTH(tpu_pkg::DATA_BITS)) w_buf (
        .clk_i(clk_i), .req_i(w_req), .wdata_i(w_req.wdata), .rdata_o(w_rdata)
    );

    // result rows, written only by result_store
    global_buffer #(
        .ADDR_BITS(tpu_pkg::ADDR_BITS),
        .WIDTH($bits(tpu_pkg::acc_row_t))
    ) c_buf (
        .clk_i(clk_i), .req_i(c_req), .wdata_i(c_wdata), .rdata_o(c_rdata)
    );

    // *********************************************************************
    // MAC rows
    // *********************************************************************
    for (genvar i = 0; i < ROWS; i++) begin : g_row
        pe_row pe_row_i (
            .clk_i(clk_i), .rst_i(rst_i), .clear_i(start), .step_i(step),
            .a_op_i(row_ops[i]), .acc_o(acc_rows[i])
        );
    end

    result_store #(.ROWS(ROWS)) result_store_i (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(load_done),
        .st_idx_wr_i(st_idx_wr), .st_idx_sel_i(st_idx_sel), .st_idx_val_i(st_idx_val),
        .acc_i(acc_rows), .c_req_o(st_c_req), .c_wdata_o(c_wdata), .done_o(store_done)
    );

endmodule

// ==== source/tpu_cmd_ctrl.sv ====
`timescale 1ns/100ps

module tpu_cmd_ctrl #(
    parameter int ROWS = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t                       cmd_i,
    input  tpu_pkg::ram_req_t                       ld_a_req_i,
    input  tpu_pkg::ram_req_t                       ld_w_req_i,
    input  tpu_pkg::ram_req_t                       st_c_req_i,
    input  logic [tpu_pkg::DATA_BITS-1:0]           a_rdata_i,
    input  logic [tpu_pkg::DATA_BITS-1:0]           w_rdata_i,
    input  tpu_pkg::acc_row_t                       c_rdata_i,
    input  logic                                    store_done_i,
    output logic                                    start_o,
    output logic [tpu_pkg::ADDR_BITS-1:0]           k_o,
    output logic [ROWS-1:0][tpu_pkg::ADDR_BITS-1:0] row_idx_o,
    output logic                                    st_idx_wr_o,
    output logic [tpu_pkg::DATA_BITS-1:0]           st_idx_sel_o,
    output logic [tpu_pkg::ADDR_BITS-1:0]           st_idx_val_o,
    output tpu_pkg::ram_req_t                       a_req_o,
    output tpu_pkg::ram_req_t                       w_req_o,
    output tpu_pkg::ram_req_t                       c_req_o,
    output logic                                    busy_o,
    output logic                                    rdata_valid_o,
    output tpu_pkg::acc_row_t                       rdata_o
);

    localparam int PAD_BITS = $bits(tpu_pkg::acc_row_t) - tpu_pkg::DATA_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_STORE
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic               accept;
    logic               is_write;
    tpu_pkg::ram_req_t  sw_req;
    tpu_pkg::ram_sel_e  rd_sel_q;
    logic               rd_v_q;

    // commands only land while idle
    assign busy_o  = (state_q != ST_IDLE);
    assign accept  = cmd_valid_i && !busy_o;
    assign start_o = accept && (cmd_i.op == tpu_pkg::OP_TRIGGER);

    // *********************************************************************
    // configuration registers
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            k_o       <= '0;
            row_idx_o <= '0;
        end else if (accept) begin
            if (cmd_i.op == tpu_pkg::OP_SET_K) begin
                k_o <= cmd_i.param_2[tpu_pkg::ADDR_BITS-1:0];
            end
            if (cmd_i.op == tpu_pkg::OP_SET_ROW_IDX) begin
                for (int i = 0; i < ROWS; i++) begin
                    if (cmd_i.param_1 == i) begin
                        row_idx_o[i] <= cmd_i.param_2[tpu_pkg::ADDR_BITS-1:0];
                    end
                end
            end
        end
    end

    // store indices live in result_store
    assign st_idx_wr_o  = accept && (cmd_i.op == tpu_pkg::OP_SET_ST_IDX);
    assign st_idx_sel_o = cmd_i.param_1;
    assign st_idx_val_o = cmd_i.param_2[tpu_pkg::ADDR_BITS-1:0];

    // *********************************************************************
    // run sequencer
    // *********************************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (start_o) state_d = ST_RUN;
            // first C write marks the store phase
            ST_RUN:   if (st_c_req_i.wr_en) state_d = ST_STORE;
            ST_STORE: if (store_done_i) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // *********************************************************************
    // buffer port mux, software when idle, engine when busy
    // *********************************************************************
    always_comb begin
        is_write     = (cmd_i.op == tpu_pkg::OP_WRITE_A) || (cmd_i.op == tpu_pkg::OP_WRITE_W);
        sw_req.wr_en = 1'b0;
        // writes index on param_1, reads on param_2
        sw_req.index = is_write ? cmd_i.param_1[tpu_pkg::ADDR_BITS-1:0]
                                : cmd_i.param_2[tpu_pkg::ADDR_BITS-1:0];
        sw_req.wdata = cmd_i.param_2;
        a_req_o       = sw_req;
        w_req_o       = sw_req;
        c_req_o       = sw_req;
        a_req_o.wr_en = accept && (cmd_i.op == tpu_pkg::OP_WRITE_A);
        w_req_o.wr_en = accept && (cmd_i.op == tpu_pkg::OP_WRITE_W);
        if (busy_o) begin
            a_req_o = ld_a_req_i;
            w_req_o = ld_w_req_i;
            c_req_o = st_c_req_i;
        end
    end

    // *********************************************************************
    // read return, RAM cycle then output register
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_v_q        <= 1'b0;
            rdata_valid_o <= 1'b0;
        end else begin
            rd_v_q        <= accept && (cmd_i.op == tpu_pkg::OP_READ_RAM);
            rdata_valid_o <= rd_v_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && (cmd_i.op == tpu_pkg::OP_READ_RAM)) begin
            rd_sel_q <= tpu_pkg::ram_sel_e'(cmd_i.param_1[1:0]);
        end
        if (rd_v_q) begin
            case (rd_sel_q)
                tpu_pkg::RAM_A: rdata_o <= {{PAD_BITS{1'b0}}, a_rdata_i};
                tpu_pkg::RAM_W: rdata_o <= {{PAD_BITS{1'b0}}, w_rdata_i};
                tpu_pkg::RAM_C: rdata_o <= c_rdata_i;
                // unused select reads zero
                default:        rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== source/result_store.sv ====
`timescale 1ns/100ps

module result_store #(
    parameter int ROWS = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                start_i,
    input  logic                                st_idx_wr_i,
    input  logic [tpu_pkg::DATA_BITS-1:0]       st_idx_sel_i,
    input  logic [tpu_pkg::ADDR_BITS-1:0]       st_idx_val_i,
    input  tpu_pkg::acc_row_t [ROWS-1:0]        acc_i,
    output tpu_pkg::ram_req_t                   c_req_o,
    output tpu_pkg::acc_row_t                   c_wdata_o,
    output logic                                done_o
);

    localparam int SLOT_BITS = (ROWS > 1) ? $clog2(ROWS) : 1;

    logic                                   wait_q;
    logic                                   drain_q;
    logic [SLOT_BITS-1:0]                   row_q;
    logic [ROWS-1:0][tpu_pkg::ADDR_BITS-1:0] st_idx_q;
    logic                                   drain_end;

    assign drain_end = drain_q && (row_q == SLOT_BITS'(ROWS - 1));

    // one C write per cycle while draining
    always_comb begin
        c_req_o       = '0;
        c_req_o.wr_en = drain_q;
        c_req_o.index = st_idx_q[row_q];
    end

    assign c_wdata_o = acc_i[row_q];

    // *********************************************************************
    // wait one cycle for the last step, then drain rows
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wait_q  <= 1'b0;
            drain_q <= 1'b0;
            row_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            wait_q <= start_i;
            done_o <= drain_end;
            if (wait_q) begin
                drain_q <= 1'b1;
                row_q   <= '0;
            end else if (drain_end) begin
                drain_q <= 1'b0;
            end else if (drain_q) begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    // store indices, set by software, step by one after each run
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            st_idx_q <= '0;
        end else if (drain_end) begin
            for (int i = 0; i < ROWS; i++) begin
                st_idx_q[i] <= st_idx_q[i] + 1'b1;
            end
        end else if (st_idx_wr_i) begin
            for (int i = 0; i < ROWS; i++) begin
                if (st_idx_sel_i == i) begin
                    st_idx_q[i] <= st_idx_val_i;
                end
            end
        end
    end

endmodule

// ==== source/operand_loader.sv ====
`timescale 1ns/100ps

module operand_loader #(
    parameter int ROWS = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    start_i,
    input  logic [tpu_pkg::ADDR_BITS-1:0]           k_i,
    input  logic [ROWS-1:0][tpu_pkg::ADDR_BITS-1:0] row_idx_i,
    input  logic [tpu_pkg::DATA_BITS-1:0]           a_rdata_i,
    input  logic [tpu_pkg::DATA_BITS-1:0]           w_rdata_i,
    output tpu_pkg::ram_req_t                       a_req_o,
    output tpu_pkg::ram_req_t                       w_req_o,
    output tpu_pkg::mac_step_t                      step_o,
    output tpu_pkg::sbyte_t [ROWS-1:0]              row_ops_o,
    output logic                                    load_done_o
);

    localparam int SLOT_BITS = (ROWS > 1) ? $clog2(ROWS) : 1;

    // issue side
    logic                           active_q;
    logic [SLOT_BITS-1:0]           slot_q;
    logic [tpu_pkg::ADDR_BITS-1:0]  step_q;
    logic [tpu_pkg::ADDR_BITS-1:0]  last_step;
    logic                           slot_end;
    // data return side, one cycle behind
    logic                           rd_v_q;
    logic                           rd_last_q;
    logic [SLOT_BITS-1:0]           rd_slot_q;
    // step packet
    logic                           step_v_q;
    logic                           step_last_q;
    tpu_pkg::w_word_u               w_q;
    tpu_pkg::sbyte_t [ROWS-1:0]     ops_q;

    // K of zero runs one step
    assign last_step = (k_i == '0) ? '0 : k_i - 1'b1;
    assign slot_end  = (slot_q == SLOT_BITS'(ROWS - 1));

    // A at row start plus step, W at step
    always_comb begin
        a_req_o       = '0;
        a_req_o.index = row_idx_i[slot_q] + step_q;
        w_req_o       = '0;
        w_req_o.index = step_q;
    end

    // *********************************************************************
    // step and slot counters
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q <= 1'b0;
            slot_q   <= '0;
            step_q   <= '0;
        end else if (start_i) begin
            active_q <= 1'b1;
            slot_q   <= '0;
            step_q   <= '0;
        end else if (active_q) begin
            slot_q <= slot_end ? '0 : slot_q + 1'b1;
            if (slot_end) begin
                step_q <= step_q + 1'b1;
                if (step_q == last_step) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // track which slot the returning data belongs to
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_v_q      <= 1'b0;
            rd_last_q   <= 1'b0;
            rd_slot_q   <= '0;
            step_v_q    <= 1'b0;
            step_last_q <= 1'b0;
        end else begin
            rd_v_q      <= active_q;
            rd_slot_q   <= slot_q;
            rd_last_q   <= active_q && slot_end && (step_q == last_step);
            step_v_q    <= rd_v_q && (rd_slot_q == SLOT_BITS'(ROWS - 1));
            step_last_q <= rd_v_q && rd_last_q;
        end
    end

    // gather operands, W comes back with slot 0
    always_ff @(posedge clk_i) begin
        if (rd_v_q) begin
            ops_q[rd_slot_q] <= a_rdata_i[7:0];
            if (rd_slot_q == '0) begin
                w_q.raw <= w_rdata_i;
            end
        end
    end

    always_comb begin
        step_o.valid = step_v_q;
        step_o.last  = step_last_q;
        step_o.w     = w_q;
    end

    assign row_ops_o   = ops_q;
    assign load_done_o = step_v_q && step_last_q;

endmodule

// ==== source/pe_row.sv ====
`timescale 1ns/100ps

module pe_row (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                clear_i,
    input  tpu_pkg::mac_step_t  step_i,
    input  tpu_pkg::sbyte_t     a_op_i,
    output tpu_pkg::acc_row_t   acc_o
);

    // *********************************************************************
    // four signed MAC lanes sharing one row operand
    // *********************************************************************
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            acc_o <= '0;
        end else if (step_i.valid) begin
            for (int j = 0; j < tpu_pkg::LANES; j++) begin
                // signed 8x8 product, 32-bit wrap
                acc_o[j] <= $signed(acc_o[j]) + a_op_i * $signed(step_i.w.lane[j]);
            end
        end
    end

endmodule

// ==== source/global_buffer.sv ====
`timescale 1ns/100ps

module global_buffer #(
    parameter int ADDR_BITS = 8,
    parameter int WIDTH     = 32
) (
    input  logic                clk_i,
    input  tpu_pkg::ram_req_t   req_i,
    input  logic [WIDTH-1:0]    wdata_i,
    output logic [WIDTH-1:0]    rdata_o
);

    logic [WIDTH-1:0]       mem [2**ADDR_BITS];
    logic [ADDR_BITS-1:0]   addr;

    assign addr = req_i.index;

    // single port, read returns old word on a write
    always_ff @(posedge clk_i) begin
        if (req_i.wr_en) begin
            mem[addr] <= wdata_i;
        end
        rdata_o <= mem[addr];
    end

endmodule

// ==== source/tpu_pkg.sv ====
package tpu_pkg;

    // *********************************************************************
    // word and buffer sizes
    // *********************************************************************
    localparam int DATA_BITS = 32;
    localparam int ADDR_BITS = 8;
    // byte lanes per W word, also the column count
    localparam int LANES = 4;
    localparam int ACC_BITS = 32;

    // *********************************************************************
    // command port
    // *********************************************************************
    typedef enum logic [7:0] {
        OP_TRIGGER     = 8'd1,   // run K steps, then store
        OP_WRITE_A     = 8'd2,   // param_1 index, param_2 data
        OP_WRITE_W     = 8'd5,   // param_1 index, param_2 data
        OP_READ_RAM    = 8'd6,   // param_1 select, param_2 index
        OP_SET_ROW_IDX = 8'd13,  // param_1 row, param_2 start index
        OP_SET_K       = 8'd14,  // param_2 inner dimension
        OP_SET_ST_IDX  = 8'd15   // param_1 row, param_2 store index
    } tpu_op_e;

    // read select, value 1 unused
    typedef enum logic [1:0] {
        RAM_A = 2'd0,
        RAM_C = 2'd2,
        RAM_W = 2'd3
    } ram_sel_e;

    typedef struct packed {
        tpu_op_e                op;
        logic [DATA_BITS-1:0]   param_1;
        logic [DATA_BITS-1:0]   param_2;
    } tpu_cmd_t;

    // *********************************************************************
    // datapath words
    // *********************************************************************
    typedef logic signed [7:0] sbyte_t;

    // raw for software, signed lanes for the MAC rows
    typedef union packed {
        logic [DATA_BITS-1:0]   raw;
        sbyte_t [LANES-1:0]     lane;
    } w_word_u;

    // one buffer port request
    typedef struct packed {
        logic                   wr_en;
        logic [ADDR_BITS-1:0]   index;
        logic [DATA_BITS-1:0]   wdata;
    } ram_req_t;

    // weight part of a step, row operands travel beside it
    typedef struct packed {
        logic       valid;
        logic       last;
        w_word_u    w;
    } mac_step_t;

    // four accumulators, also one C word
    typedef logic [LANES-1:0][ACC_BITS-1:0] acc_row_t;

endpackage
